/* verilog/alu_pkg.sv */
`default_nettype none

package alu_pkg;

	// Operand and result width
	localparam int unsigned DATA_WIDTH = 8;

	// Bit counter runs 0 .. DATA_WIDTH-1
	localparam int unsigned CNT_WIDTH = 3;

	// Bit positions of the compare relation code
	localparam int unsigned REL_GT = 0; // a > b
	localparam int unsigned REL_EQ = 1; // a == b
	localparam int unsigned REL_LT = 2; // a < b

	// Opcodes
	typedef enum logic [1:0]
	{
		OP_ADD  = 2'b00,
		OP_SUB  = 2'b01,
		OP_PAR  = 2'b10,
		OP_COMP = 2'b11
	} alu_op_e;

	// Sequencer states
	typedef enum logic [1:0]
	{
		S_IDLE = 2'b00,
		S_RUN  = 2'b01,
		S_DONE = 2'b10
	} seq_state_e;

endpackage

`default_nettype wire

/* verilog/alu_serial_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface alu_serial_if import alu_pkg::*; ();

	// Sequencer to execution units
	alu_op_e                op;
	logic                   step;   // High on every run cycle
	logic                   first;  // First run cycle only
	logic                   bit_a;  // LSB first
	logic                   bit_b;

	// Execution units back to sequencer
	logic [DATA_WIDTH-1:0]  addsub_result;
	logic                   addsub_flag;
	logic [DATA_WIDTH-1:0]  logic_result;

	modport seq
	(
		output op,
		output step,
		output first,
		output bit_a,
		output bit_b,
		input  addsub_result,
		input  addsub_flag,
		input  logic_result
	);

	modport arith
	(
		input  op,
		input  step,
		input  first,
		input  bit_a,
		input  bit_b,
		output addsub_result,
		output addsub_flag
	);

	modport logic_unit
	(
		input  op,
		input  step,
		input  first,
		input  bit_a,
		input  bit_b,
		output logic_result
	);

endinterface

`default_nettype wire

/* verilog/alu_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_sequencer import alu_pkg::*;
(
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire [DATA_WIDTH-1:0]    alu_data,
	input  wire alu_op_e            opcode_value,
	input  wire                     store_a,
	input  wire                     store_b,
	input  wire                     start,
	output logic                    alu_done,
	output logic [DATA_WIDTH-1:0]   result,
	output logic                    overflow_def,
	alu_serial_if.seq               sif
);

	seq_state_e             state_q;
	seq_state_e             state_d;
	logic [CNT_WIDTH-1:0]   cnt_q;
	alu_op_e                op_q;

	logic [DATA_WIDTH-1:0]  buf_a;
	logic [DATA_WIDTH-1:0]  buf_b;
	logic [DATA_WIDTH-1:0]  shift_a;
	logic [DATA_WIDTH-1:0]  shift_b;

	logic                   idle;
	logic                   running;
	logic                   accept;
	logic                   last_bit;

	logic [DATA_WIDTH-1:0]  sel_result;
	logic                   sel_flag;

	assign idle     = (state_q == S_IDLE);
	assign running  = (state_q == S_RUN);
	assign accept   = idle && start;   // Starts while busy are dropped
	assign last_bit = (cnt_q == CNT_WIDTH'(DATA_WIDTH - 1));

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			S_IDLE:
			begin
				if (start)
					state_d = S_RUN;
			end
			S_RUN:
			begin
				if (last_bit)
					state_d = S_DONE;
			end
			S_DONE:
			begin
				state_d = S_IDLE;
			end
			default:
			begin
				state_d = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q <= S_IDLE;
			cnt_q   <= '0;
			op_q    <= OP_ADD;
		end
		else
		begin
			state_q <= state_d;
			if (accept)
			begin
				op_q  <= opcode_value;
				cnt_q <= '0;
			end
			else if (running)
				cnt_q <= cnt_q + 1'b1; // Wraps to 0 after last bit
		end
	end

	// Operand buffers, store_a has priority
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			buf_a <= '0;
			buf_b <= '0;
		end
		else if (idle)
		begin
			if (store_a)
				buf_a <= alu_data;
			else if (store_b)
				buf_b <= alu_data;
		end
	end

	// Working copies, shifted right one bit per run cycle
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			shift_a <= buf_a;
			shift_b <= buf_b;
		end
		else if (running)
		begin
			shift_a <= shift_a >> 1;
			shift_b <= shift_b >> 1;
		end
	end

	assign sif.op    = op_q;
	assign sif.step  = running;
	assign sif.first = running && (cnt_q == '0);
	assign sif.bit_a = shift_a[0];
	assign sif.bit_b = shift_b[0];

	always_comb
	begin
		case (op_q)
			OP_ADD, OP_SUB:
			begin
				sel_result = sif.addsub_result;
				sel_flag   = sif.addsub_flag;
			end
			default:
			begin
				sel_result = sif.logic_result;
				sel_flag   = 1'b0;
			end
		endcase
	end

	// Result and flag stay put until the next operation completes
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			alu_done     <= 1'b0;
			result       <= '0;
			overflow_def <= 1'b0;
		end
		else
		begin
			alu_done <= (state_q == S_DONE);
			if (state_q == S_DONE)
			begin
				result       <= sel_result;
				overflow_def <= sel_flag;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/serial_addsub.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_addsub import alu_pkg::*;
(
	input  wire          clk,
	input  wire          rst_n,
	alu_serial_if.arith  sif
);

	logic                   enable;
	logic                   is_sub;
	logic                   cy_in;
	logic                   cy_q;
	logic                   cy_next;
	logic                   res_bit;
	logic                   half;
	logic [DATA_WIDTH-1:0]  res_q;

	assign is_sub = (sif.op == OP_SUB);
	assign enable = sif.step && (sif.op == OP_ADD || is_sub);

	// Carry in and borrow in are always 0 on the first bit
	assign cy_in = sif.first ? 1'b0 : cy_q;

	assign half = sif.bit_a ^ sif.bit_b;

	always_comb
	begin
		res_bit = half ^ cy_in; // Same for sum and difference
		if (is_sub)
		begin
			// Borrow when b plus borrow exceeds a
			cy_next = (~sif.bit_a & sif.bit_b) | (~half & cy_in);
		end
		else
		begin
			cy_next = (sif.bit_a & sif.bit_b) | (half & cy_in);
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cy_q <= 1'b0;
		else if (enable)
			cy_q <= cy_next;
	end

	// New bit enters at the top, word is LSB aligned after the last step
	always_ff @(posedge clk)
	begin
		if (enable)
			res_q <= {res_bit, res_q[DATA_WIDTH-1:1]};
	end

	assign sif.addsub_result = res_q;
	assign sif.addsub_flag   = cy_q;    // Carry out or borrow out

endmodule

`default_nettype wire

/* verilog/serial_logic.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_logic import alu_pkg::*;
(
	input  wire               clk,
	input  wire               rst_n,
	alu_serial_if.logic_unit  sif
);

	logic [REL_LT:0]        rel_q;
	logic [REL_LT:0]        rel_in;
	logic [REL_LT:0]        rel_next;
	logic [DATA_WIDTH-1:0]  par_q;

	// Relation restarts as equal on the first bit
	always_comb
	begin
		rel_in = rel_q;
		if (sif.first)
		begin
			rel_in         = '0;
			rel_in[REL_EQ] = 1'b1;
		end
	end

	// A differing bit overrides everything below it
	always_comb
	begin
		rel_next = rel_in;
		if (sif.bit_a != sif.bit_b)
		begin
			rel_next = '0;
			if (sif.bit_a)
				rel_next[REL_GT] = 1'b1;
			else
				rel_next[REL_LT] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rel_q         <= '0;
			rel_q[REL_EQ] <= 1'b1;
		end
		else if (sif.step)
			rel_q <= rel_next;
	end

	always_ff @(posedge clk)
	begin
		if (sif.step)
			par_q <= {sif.bit_a ^ sif.bit_b, par_q[DATA_WIDTH-1:1]};
	end

	// Compare code sits in the low bits, zeros above
	assign sif.logic_result = (sif.op == OP_COMP) ? DATA_WIDTH'(rel_q) : par_q;

endmodule

`default_nettype wire

/* verilog/alu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_top import alu_pkg::*;
(
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire [DATA_WIDTH-1:0]    alu_data,
	input  wire alu_op_e            opcode_value,
	input  wire                     store_a,
	input  wire                     store_b,
	input  wire                     start,
	output wire                     alu_done,
	output wire [DATA_WIDTH-1:0]    result,
	output wire                     overflow_def
);

	alu_serial_if sif ();

	// Buffers, FSM and result select
	alu_sequencer u_seq
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.alu_data     (alu_data),
		.opcode_value (opcode_value),
		.store_a      (store_a),
		.store_b      (store_b),
		.start        (start),
		.alu_done     (alu_done),
		.result       (result),
		.overflow_def (overflow_def),
		.sif          (sif.seq)
	);

	serial_addsub u_addsub
	(
		.clk   (clk),
		.rst_n (rst_n),
		.sif   (sif.arith)
	);

	// Parity and compare
	serial_logic u_logic
	(
		.clk   (clk),
		.rst_n (rst_n),
		.sif   (sif.logic_unit)
	);

endmodule

`default_nettype wire

/* verification/alu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_tb import alu_pkg::*; ();

	localparam int CLK_PERIOD      = 20;
	localparam int RESET_CYCLES    = 5;
	localparam int NUM_FIXED       = 17;
	localparam int NUM_RANDOM      = 20;
	localparam int NUM_ROWS        = NUM_FIXED + NUM_RANDOM;
	localparam int DONE_LIMIT      = 4 * DATA_WIDTH;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * (DATA_WIDTH + 8) + RESET_CYCLES;
	localparam logic [31:0] RAND_SEED = 32'h9869_28fe;

	logic                   clk;
	logic                   rst_n;
	logic [DATA_WIDTH-1:0]  alu_data;
	alu_op_e                opcode_value;
	logic                   store_a;
	logic                   store_b;
	logic                   start;
	wire                    alu_done;
	wire [DATA_WIDTH-1:0]   result;
	wire                    overflow_def;

	// Stimulus table
	logic [DATA_WIDTH-1:0]  row_a [NUM_ROWS];
	logic [DATA_WIDTH-1:0]  row_b [NUM_ROWS];
	alu_op_e                row_op [NUM_ROWS];
	int                     row_gap [NUM_ROWS];
	bit                     row_busy [NUM_ROWS];   // Disturb the run with store_a and start
	bit                     row_reuse [NUM_ROWS];  // Keep buffer A from the row before

	int unsigned            seed_init;

	alu_top UUT
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.alu_data     (alu_data),
		.opcode_value (opcode_value),
		.store_a      (store_a),
		.store_b      (store_b),
		.start        (start),
		.alu_done     (alu_done),
		.result       (result),
		.overflow_def (overflow_def)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] expected,
		input logic [DATA_WIDTH-1:0] actual);
		assert (actual === expected)
		else
			stop_on_error($sformatf("Error: time %0t, %s: expected 0x%0h, actual 0x%0h",
				$time, name, expected, actual));
	endtask

	function automatic logic [DATA_WIDTH-1:0] expected_result(input logic [DATA_WIDTH-1:0] a,
		input logic [DATA_WIDTH-1:0] b, input alu_op_e op);
		logic [DATA_WIDTH:0]    wide;
		logic [DATA_WIDTH-1:0]  res;
		res = '0;
		case (op)
			OP_ADD:
			begin
				wide = {1'b0, a} + {1'b0, b};
				res  = wide[DATA_WIDTH-1:0];
			end
			OP_SUB:
			begin
				wide = {1'b0, a} - {1'b0, b};
				res  = wide[DATA_WIDTH-1:0];
			end
			OP_PAR:
				res = a ^ b;
			default:
			begin
				if (a > b)
					res[REL_GT] = 1'b1;
				else if (a == b)
					res[REL_EQ] = 1'b1;
				else
					res[REL_LT] = 1'b1;
			end
		endcase
		return res;
	endfunction

	function automatic logic expected_flag(input logic [DATA_WIDTH-1:0] a,
		input logic [DATA_WIDTH-1:0] b, input alu_op_e op);
		logic [DATA_WIDTH:0] wide;
		wide = {1'b0, a} + {1'b0, b};
		if (op == OP_ADD)
			return wide[DATA_WIDTH]; // Unsigned carry out
		else if (op == OP_SUB)
			return (b > a);
		else
			return 1'b0;
	endfunction

	task automatic set_row(input int idx, input logic [DATA_WIDTH-1:0] a,
		input logic [DATA_WIDTH-1:0] b, input alu_op_e op, input int gap,
		input bit busy, input bit reuse);
		row_a[idx]     = a;
		row_b[idx]     = b;
		row_op[idx]    = op;
		row_gap[idx]   = gap;
		row_busy[idx]  = busy;
		row_reuse[idx] = reuse;
	endtask

	task automatic load_table();
		logic [1:0] op_bits;
		set_row(0,  8'hFF, 8'h01, OP_ADD,  1, 0, 0);
		set_row(1,  8'h80, 8'h80, OP_ADD,  0, 0, 0);
		set_row(2,  8'h00, 8'h00, OP_ADD,  1, 0, 0);
		set_row(3,  8'h7F, 8'h01, OP_ADD,  0, 0, 0);
		set_row(4,  8'h55, 8'h55, OP_SUB,  1, 0, 0);
		set_row(5,  8'h00, 8'h01, OP_SUB,  0, 0, 0);
		set_row(6,  8'hC3, 8'h42, OP_SUB,  1, 0, 0);
		set_row(7,  8'h10, 8'h80, OP_SUB,  0, 0, 0);
		set_row(8,  8'hA5, 8'h5A, OP_PAR,  1, 0, 0);
		set_row(9,  8'hFF, 8'h0F, OP_PAR,  0, 0, 0);
		set_row(10, 8'h80, 8'h00, OP_COMP, 1, 0, 0); // MSB only
		set_row(11, 8'h00, 8'h80, OP_COMP, 0, 0, 0);
		set_row(12, 8'h01, 8'h00, OP_COMP, 1, 0, 0); // LSB only
		set_row(13, 8'h3C, 8'h3D, OP_COMP, 0, 0, 0);
		set_row(14, 8'h99, 8'h99, OP_COMP, 1, 0, 0);
		set_row(15, 8'h12, 8'h34, OP_ADD,  0, 1, 0);
		set_row(16, 8'h12, 8'h07, OP_SUB,  1, 0, 1); // Buffer A must still be 0x12
		for (int i = NUM_FIXED; i < NUM_ROWS; i++)
		begin
			op_bits = 2'($urandom % 4);
			set_row(i, DATA_WIDTH'($urandom), DATA_WIDTH'($urandom), alu_op_e'(op_bits),
				int'($urandom % 2), 0, 0);
		end
	endtask

	task automatic run_row(input int idx);
		logic [DATA_WIDTH-1:0]  exp_res;
		logic                   exp_flag;
		int                     edges;
		bit                     got_done;
		exp_res  = expected_result(row_a[idx], row_b[idx], row_op[idx]);
		exp_flag = expected_flag(row_a[idx], row_b[idx], row_op[idx]);
		if (!row_reuse[idx])
		begin
			@(posedge clk);
			alu_data <= row_a[idx];
			store_a  <= 1'b1;
		end
		@(posedge clk);
		alu_data <= row_b[idx];
		store_a  <= 1'b0;
		store_b  <= 1'b1;
		@(posedge clk);
		store_b      <= 1'b0;
		opcode_value <= row_op[idx];
		start        <= 1'b1;
		@(posedge clk); // Start edge
		start    <= 1'b0;
		edges    = 0;
		got_done = 1'b0;
		while (!got_done && edges < DONE_LIMIT)
		begin
			@(posedge clk);
			edges++;
			if (row_busy[idx] && edges == 3)
			begin
				alu_data     <= ~row_a[idx];
				store_a      <= 1'b1;
				start        <= 1'b1;
				opcode_value <= OP_COMP;
			end
			else if (row_busy[idx] && edges == 4)
			begin
				store_a <= 1'b0;
				start   <= 1'b0;
			end
			@(negedge clk);
			got_done = alu_done;
		end
		assert (got_done)
		else
			stop_on_error($sformatf("alu_done never arrived for row %0d", idx));
		assert (edges == DATA_WIDTH + 1)
		else
			stop_on_error($sformatf("Error: time %0t, alu_done latency: expected %0d, actual %0d",
				$time, DATA_WIDTH + 1, edges));
		check_value("result", exp_res, result);
		check_value("overflow_def", DATA_WIDTH'(exp_flag), DATA_WIDTH'(overflow_def));
		// Single cycle pulse, result stays put
		@(posedge clk);
		@(negedge clk);
		check_value("alu_done", '0, DATA_WIDTH'(alu_done));
		check_value("result", exp_res, result);
		repeat (row_gap[idx])
		begin
			@(posedge clk);
			@(negedge clk);
			check_value("result", exp_res, result);
			check_value("overflow_def", DATA_WIDTH'(exp_flag), DATA_WIDTH'(overflow_def));
		end
	endtask

	initial
	begin
		seed_init    = $urandom(RAND_SEED);
		rst_n        = 1'b0;
		alu_data     = '0;
		opcode_value = OP_ADD;
		store_a      = 1'b0;
		store_b      = 1'b0;
		start        = 1'b0;
		load_table();
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("alu_done", '0, DATA_WIDTH'(alu_done));
		check_value("result", '0, result);
		check_value("overflow_def", '0, DATA_WIDTH'(overflow_def));
		for (int i = 0; i < NUM_ROWS; i++)
			run_row(i);
		$display("STATUS: PASS");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		stop_on_error("Timeout: the test did not finish in the expected time");
	end

endmodule

`default_nettype wire

/* tb.f */
verilog/alu_pkg.sv
verilog/alu_serial_if.sv
verilog/alu_sequencer.sv
verilog/serial_addsub.sv
verilog/serial_logic.sv
verilog/alu_top.sv
verification/alu_tb.sv

/* Bender.yml */
package:
  name: serial_alu

sources:
  - verilog/alu_pkg.sv
  - verilog/alu_serial_if.sv
  - verilog/alu_sequencer.sv
  - verilog/serial_addsub.sv
  - verilog/serial_logic.sv
  - verilog/alu_top.sv
  - target: test
    files:
      - verification/alu_tb.sv
